// ==== hdl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path
`define CORE_WORD_WIDTH 32

// General registers
`define CORE_REG_ADDR_WIDTH 5
`define CORE_REG_COUNT (1 << `CORE_REG_ADDR_WIDTH)

// Shift amount field of R-type shifts
`define CORE_SHAMT_WIDTH 5

`endif

// ==== hdl/mips_isa_pkg.sv ====
`include "core_settings.svh"

package mips_isa_pkg;

	typedef logic [`CORE_WORD_WIDTH-1:0]     Word_t;
	typedef logic [`CORE_REG_ADDR_WIDTH-1:0] RegAddr_t;
	typedef logic [31:0]                     Inst_t;
	typedef logic [5:0]                      Opcode_t;
	typedef logic [5:0]                      Funct_t;

	// Primary opcodes
	localparam Opcode_t OP_SPECIAL = 6'b000000;
	localparam Opcode_t OP_ADDIU   = 6'b001001;
	localparam Opcode_t OP_SLTI    = 6'b001010;
	localparam Opcode_t OP_ANDI    = 6'b001100;
	localparam Opcode_t OP_ORI     = 6'b001101;
	localparam Opcode_t OP_XORI    = 6'b001110;
	localparam Opcode_t OP_LUI     = 6'b001111;

	// Function codes under SPECIAL
	localparam Funct_t FUNCT_SLL  = 6'b000000;
	localparam Funct_t FUNCT_SRL  = 6'b000010;
	localparam Funct_t FUNCT_ADDU = 6'b100001;
	localparam Funct_t FUNCT_SUBU = 6'b100011;
	localparam Funct_t FUNCT_AND  = 6'b100100;
	localparam Funct_t FUNCT_OR   = 6'b100101;
	localparam Funct_t FUNCT_XOR  = 6'b100110;
	localparam Funct_t FUNCT_SLT  = 6'b101010;
	localparam Funct_t FUNCT_SLTU = 6'b101011;

endpackage

// ==== hdl/pipe_pkg.sv ====
`include "core_settings.svh"

package pipe_pkg;

	typedef logic [`CORE_SHAMT_WIDTH-1:0] Shamt_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} AluOp_t;

	typedef struct packed {
		logic                   we;
		mips_isa_pkg::RegAddr_t waddr;
		mips_isa_pkg::Word_t    wdata;
	} RegWriteReq_t;

	// One lane after decode, before operands are known
	typedef struct packed {
		AluOp_t                 op;
		mips_isa_pkg::RegAddr_t rs;
		mips_isa_pkg::RegAddr_t rt;
		logic                   use_imm;
		mips_isa_pkg::Word_t    imm;
		Shamt_t                 shamt;
		RegWriteReq_t           wr;
	} DecodedOp_t;

	typedef struct packed {
		mips_isa_pkg::Inst_t inst_a;
		mips_isa_pkg::Inst_t inst_b;
	} InstPair_t;

endpackage

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
	input  mips_isa_pkg::Inst_t  inst,
	output pipe_pkg::DecodedOp_t op
);

	mips_isa_pkg::Opcode_t  opcode;
	mips_isa_pkg::Funct_t   funct;
	mips_isa_pkg::RegAddr_t rt;
	mips_isa_pkg::RegAddr_t rd;
	mips_isa_pkg::RegAddr_t dest;
	logic [15:0]            imm16;
	logic                   supported;

	assign opcode = inst[31:26];
	assign funct  = inst[5:0];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign imm16  = inst[15:0];

	always_comb
	begin
		supported  = 1'b1;
		dest       = rt;
		op.op      = pipe_pkg::ALU_ADD;
		op.rs      = inst[25:21];
		op.rt      = rt;
		op.use_imm = 1'b1;
		// Sign extended unless the opcode says otherwise
		op.imm     = {{16{imm16[15]}}, imm16};
		op.shamt   = inst[10:6];

		if (opcode == mips_isa_pkg::OP_SPECIAL)
		begin
			dest       = rd;
			op.use_imm = 1'b0;
			case (funct)
				mips_isa_pkg::FUNCT_ADDU: op.op = pipe_pkg::ALU_ADD;
				mips_isa_pkg::FUNCT_SUBU: op.op = pipe_pkg::ALU_SUB;
				mips_isa_pkg::FUNCT_AND:  op.op = pipe_pkg::ALU_AND;
				mips_isa_pkg::FUNCT_OR:   op.op = pipe_pkg::ALU_OR;
				mips_isa_pkg::FUNCT_XOR:  op.op = pipe_pkg::ALU_XOR;
				mips_isa_pkg::FUNCT_SLT:  op.op = pipe_pkg::ALU_SLT;
				mips_isa_pkg::FUNCT_SLTU: op.op = pipe_pkg::ALU_SLTU;
				mips_isa_pkg::FUNCT_SLL:  op.op = pipe_pkg::ALU_SLL;
				mips_isa_pkg::FUNCT_SRL:  op.op = pipe_pkg::ALU_SRL;
				default:                  supported = 1'b0;
			endcase
		end
		else
		begin
			case (opcode)
				mips_isa_pkg::OP_ADDIU: op.op = pipe_pkg::ALU_ADD;
				mips_isa_pkg::OP_SLTI:  op.op = pipe_pkg::ALU_SLT;
				mips_isa_pkg::OP_ANDI:
				begin
					op.op  = pipe_pkg::ALU_AND;
					op.imm = {16'h0000, imm16};
				end
				mips_isa_pkg::OP_ORI:
				begin
					op.op  = pipe_pkg::ALU_OR;
					op.imm = {16'h0000, imm16};
				end
				mips_isa_pkg::OP_XORI:
				begin
					op.op  = pipe_pkg::ALU_XOR;
					op.imm = {16'h0000, imm16};
				end
				mips_isa_pkg::OP_LUI:
				begin
					op.op  = pipe_pkg::ALU_LUI;
					op.imm = {imm16, 16'h0000};
				end
				default: supported = 1'b0;
			endcase
		end

		// Unknown encodings and writes to r0 leave the lane idle
		op.wr.we    = supported && (dest != '0);
		op.wr.waddr = dest;
		op.wr.wdata = '0;
	end

endmodule

// ==== hdl/gpr_file.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module gpr_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  pipe_pkg::RegWriteReq_t wr_a,
	input  pipe_pkg::RegWriteReq_t wr_b,
	input  mips_isa_pkg::RegAddr_t raddr1,
	input  mips_isa_pkg::RegAddr_t raddr2,
	input  mips_isa_pkg::RegAddr_t raddr3,
	input  mips_isa_pkg::RegAddr_t raddr4,
	output mips_isa_pkg::Word_t    rdata1,
	output mips_isa_pkg::Word_t    rdata2,
	output mips_isa_pkg::Word_t    rdata3,
	output mips_isa_pkg::Word_t    rdata4
);

	mips_isa_pkg::Word_t regs [`CORE_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `CORE_REG_COUNT; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (wr_a.we)
				regs[wr_a.waddr] <= wr_a.wdata;
			// Lane b is later in program order
			if (wr_b.we)
				regs[wr_b.waddr] <= wr_b.wdata;
		end
	end

	function automatic mips_isa_pkg::Word_t read_port(input mips_isa_pkg::RegAddr_t addr);
		if (addr == '0)
			return '0;
		if (wr_b.we && wr_b.waddr == addr)
			return wr_b.wdata;
		if (wr_a.we && wr_a.waddr == addr)
			return wr_a.wdata;
		return regs[addr];
	endfunction

	always_comb
	begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
		rdata3 = read_port(raddr3);
		rdata4 = read_port(raddr4);
	end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  pipe_pkg::AluOp_t    op,
	input  mips_isa_pkg::Word_t src_a,
	input  mips_isa_pkg::Word_t src_b,
	input  pipe_pkg::Shamt_t    shamt,
	output mips_isa_pkg::Word_t result
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(src_a) < $signed(src_b);
	assign lt_unsigned = src_a < src_b;

	always_comb
	begin
		case (op)
			// No overflow trap, results wrap
			pipe_pkg::ALU_ADD:  result = src_a + src_b;
			pipe_pkg::ALU_SUB:  result = src_a - src_b;
			pipe_pkg::ALU_AND:  result = src_a & src_b;
			pipe_pkg::ALU_OR:   result = src_a | src_b;
			pipe_pkg::ALU_XOR:  result = src_a ^ src_b;
			pipe_pkg::ALU_SLT:  result = {{($bits(result) - 1){1'b0}}, lt_signed};
			pipe_pkg::ALU_SLTU: result = {{($bits(result) - 1){1'b0}}, lt_unsigned};
			pipe_pkg::ALU_SLL:  result = src_b << shamt;
			pipe_pkg::ALU_SRL:  result = src_b >> shamt;
			// Immediate already shifted by decode
			pipe_pkg::ALU_LUI:  result = src_b;
			default:            result = '0;
		endcase
	end

endmodule

// ==== hdl/pair_execute.sv ====
`timescale 1ns/1ps

module pair_execute (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pair_valid,
	input  pipe_pkg::DecodedOp_t   dec_a,
	input  pipe_pkg::DecodedOp_t   dec_b,
	input  mips_isa_pkg::Word_t    rdata_a1,
	input  mips_isa_pkg::Word_t    rdata_a2,
	input  mips_isa_pkg::Word_t    rdata_b1,
	input  mips_isa_pkg::Word_t    rdata_b2,
	output logic                   wb_valid,
	output pipe_pkg::RegWriteReq_t wb_a,
	output pipe_pkg::RegWriteReq_t wb_b
);

	localparam pipe_pkg::RegWriteReq_t NO_WRITE = '0;

	logic                   iss_valid;
	pipe_pkg::DecodedOp_t   iss_a;
	pipe_pkg::DecodedOp_t   iss_b;
	mips_isa_pkg::Word_t    iss_a1;
	mips_isa_pkg::Word_t    iss_a2;
	mips_isa_pkg::Word_t    iss_b1;
	mips_isa_pkg::Word_t    iss_b2;
	mips_isa_pkg::Word_t    src_a1;
	mips_isa_pkg::Word_t    src_a2;
	mips_isa_pkg::Word_t    src_b1;
	mips_isa_pkg::Word_t    src_b2;
	mips_isa_pkg::Word_t    res_a;
	mips_isa_pkg::Word_t    res_b;
	pipe_pkg::RegWriteReq_t casc_a;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			iss_valid <= 1'b0;
		else
			iss_valid <= pair_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pair_valid)
		begin
			iss_a  <= dec_a;
			iss_b  <= dec_b;
			iss_a1 <= rdata_a1;
			iss_a2 <= rdata_a2;
			iss_b1 <= rdata_b1;
			iss_b2 <= rdata_b2;
		end
	end

	// Youngest matching writer first
	function automatic mips_isa_pkg::Word_t resolve(
		input mips_isa_pkg::RegAddr_t addr,
		input mips_isa_pkg::Word_t    reg_val,
		input pipe_pkg::RegWriteReq_t cascade,
		input pipe_pkg::RegWriteReq_t older_b,
		input pipe_pkg::RegWriteReq_t older_a
	);
		if (cascade.we && cascade.waddr == addr)
			return cascade.wdata;
		if (older_b.we && older_b.waddr == addr)
			return older_b.wdata;
		if (older_a.we && older_a.waddr == addr)
			return older_a.wdata;
		return reg_val;
	endfunction

	always_comb
	begin
		src_a1 = resolve(iss_a.rs, iss_a1, NO_WRITE, wb_b, wb_a);
		src_a2 = iss_a.use_imm ? iss_a.imm : resolve(iss_a.rt, iss_a2, NO_WRITE, wb_b, wb_a);
	end

	alu alu_a (
		.op     (iss_a.op),
		.src_a  (src_a1),
		.src_b  (src_a2),
		.shamt  (iss_a.shamt),
		.result (res_a)
	);

	// Lane a result as seen by lane b of the same pair
	assign casc_a = '{we: iss_a.wr.we, waddr: iss_a.wr.waddr, wdata: res_a};

	always_comb
	begin
		src_b1 = resolve(iss_b.rs, iss_b1, casc_a, wb_b, wb_a);
		src_b2 = iss_b.use_imm ? iss_b.imm : resolve(iss_b.rt, iss_b2, casc_a, wb_b, wb_a);
	end

	alu alu_b (
		.op     (iss_b.op),
		.src_a  (src_b1),
		.src_b  (src_b2),
		.shamt  (iss_b.shamt),
		.result (res_b)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_valid <= 1'b0;
			wb_a     <= '0;
			wb_b     <= '0;
		end
		else
		begin
			wb_valid   <= iss_valid;
			wb_a.we    <= iss_valid & iss_a.wr.we;
			wb_a.waddr <= iss_a.wr.waddr;
			wb_a.wdata <= res_a;
			wb_b.we    <= iss_valid & iss_b.wr.we;
			wb_b.waddr <= iss_b.wr.waddr;
			wb_b.wdata <= res_b;
		end
	end

endmodule

// ==== hdl/dual_issue_core.sv ====
`timescale 1ns/1ps

module dual_issue_core (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   pair_valid,
	input  pipe_pkg::InstPair_t    inst_pair,
	output logic                   wb_valid,
	output pipe_pkg::RegWriteReq_t wb_a,
	output pipe_pkg::RegWriteReq_t wb_b
);

	pipe_pkg::DecodedOp_t dec_a;
	pipe_pkg::DecodedOp_t dec_b;
	mips_isa_pkg::Word_t  rdata_a1;
	mips_isa_pkg::Word_t  rdata_a2;
	mips_isa_pkg::Word_t  rdata_b1;
	mips_isa_pkg::Word_t  rdata_b2;

	inst_decode decode_a (
		.inst (inst_pair.inst_a),
		.op   (dec_a)
	);

	inst_decode decode_b (
		.inst (inst_pair.inst_b),
		.op   (dec_b)
	);

	// Writeback feeds the register file and the outside in the same cycle
	gpr_file gpr (
		.clk,
		.rst_n,
		.wr_a   (wb_a),
		.wr_b   (wb_b),
		.raddr1 (dec_a.rs),
		.raddr2 (dec_a.rt),
		.raddr3 (dec_b.rs),
		.raddr4 (dec_b.rt),
		.rdata1 (rdata_a1),
		.rdata2 (rdata_a2),
		.rdata3 (rdata_b1),
		.rdata4 (rdata_b2)
	);

	pair_execute execute (
		.clk,
		.rst_n,
		.pair_valid,
		.dec_a,
		.dec_b,
		.rdata_a1,
		.rdata_a2,
		.rdata_b1,
		.rdata_b2,
		.wb_valid,
		.wb_a,
		.wb_b
	);

endmodule

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps

`include "core_settings.svh"

module core_tb #(
	parameter int SEED = 40441
);

	typedef logic [`CORE_WORD_WIDTH-1:0]     value_t;
	typedef logic [`CORE_REG_ADDR_WIDTH-1:0] reg_t;

	localparam pipe_pkg::RegWriteReq_t NO_WRITE = '0;
	localparam int ANY_GAP = -1;

	logic                   clk = 1'b0;
	logic                   rst_n;
	logic                   pair_valid;
	pipe_pkg::InstPair_t    inst_pair;
	logic                   wb_valid;
	pipe_pkg::RegWriteReq_t wb_a;
	pipe_pkg::RegWriteReq_t wb_b;

	// Table columns, one entry per row
	string                  names[$];
	int                     gaps[$];
	pipe_pkg::InstPair_t    pairs[$];
	pipe_pkg::RegWriteReq_t exp_a[$];
	pipe_pkg::RegWriteReq_t exp_b[$];

	int strobe_cycles[$];
	int cycle = 0;
	int limit = 1000;
	int rows_done = 0;
	int rows_passed = 0;
	int rows_failed = 0;
	int errors = 0;

	dual_issue_core uut (
		.clk,
		.rst_n,
		.pair_valid,
		.inst_pair,
		.wb_valid,
		.wb_a,
		.wb_b
	);

	always #4 clk = ~clk;

	// d is rd (rt for I-type), s is rs (rt for shifts), t is rt, imm16 or shamt
	function automatic mips_isa_pkg::Inst_t assemble(string m, int d, int s, int t);
		logic [5:0] op;
		logic [5:0] fn;
		op = 6'h00;
		fn = 6'h00;
		case (m)
			"addiu": op = 6'h09;
			"slti":  op = 6'h0a;
			"andi":  op = 6'h0c;
			"ori":   op = 6'h0d;
			"xori":  op = 6'h0e;
			"lui":   op = 6'h0f;
			"lw":    op = 6'h23;
			"addu":  fn = 6'h21;
			"subu":  fn = 6'h23;
			"and":   fn = 6'h24;
			"or":    fn = 6'h25;
			"xor":   fn = 6'h26;
			"slt":   fn = 6'h2a;
			"sltu":  fn = 6'h2b;
			"srl":   fn = 6'h02;
			"sll":   fn = 6'h00;
			default: op = 6'h3f;
		endcase
		if (op != 6'h00)
			return {op, 5'(s), 5'(d), 16'(t)};
		if (m == "sll" || m == "srl")
			return {11'h000, 5'(s), 5'(d), 5'(t), fn};
		return {6'h00, 5'(s), 5'(t), 5'(d), 5'h00, fn};
	endfunction

	function automatic pipe_pkg::RegWriteReq_t wr(int addr, value_t data);
		return '{we: 1'b1, waddr: reg_t'(addr), wdata: data};
	endfunction

	task automatic add_row(string name, int gap, mips_isa_pkg::Inst_t a, mips_isa_pkg::Inst_t b,
		pipe_pkg::RegWriteReq_t ea, pipe_pkg::RegWriteReq_t eb);
		names.push_back(name);
		gaps.push_back(gap);
		pairs.push_back(pipe_pkg::InstPair_t'({a, b}));
		exp_a.push_back(ea);
		exp_b.push_back(eb);
	endtask

	// Expected values assume all registers start at zero
	task automatic build_table();
		add_row("addiu_neg_ori", ANY_GAP,
			assemble("addiu", 1, 0, 'hfff0), assemble("ori", 2, 0, 'h8001),
			wr(1, 32'hffff_fff0), wr(2, 32'h0000_8001));
		add_row("andi_xori", ANY_GAP,
			assemble("andi", 3, 1, 'h8f0f), assemble("xori", 4, 2, 'hffff),
			wr(3, 32'h0000_8f00), wr(4, 32'h0000_7ffe));
		add_row("lui_slti", ANY_GAP,
			assemble("lui", 5, 0, 'h8000), assemble("slti", 6, 1, 'h0005),
			wr(5, 32'h8000_0000), wr(6, 32'h0000_0001));
		add_row("slt_sltu", ANY_GAP,
			assemble("slt", 7, 1, 2), assemble("sltu", 8, 1, 2),
			wr(7, 32'h0000_0001), wr(8, 32'h0000_0000));
		add_row("subu_addu_wrap", ANY_GAP,
			assemble("subu", 9, 0, 2), assemble("addu", 10, 5, 5),
			wr(9, 32'hffff_7fff), wr(10, 32'h0000_0000));
		add_row("sll_srl", ANY_GAP,
			assemble("sll", 11, 2, 4), assemble("srl", 12, 5, 31),
			wr(11, 32'h0008_0010), wr(12, 32'h0000_0001));
		add_row("and_or", ANY_GAP,
			assemble("and", 13, 1, 4), assemble("or", 14, 3, 4),
			wr(13, 32'h0000_7ff0), wr(14, 32'h0000_fffe));
		add_row("cascade", ANY_GAP,
			assemble("addiu", 15, 2, 'h0010), assemble("xor", 16, 15, 4),
			wr(15, 32'h0000_8011), wr(16, 32'h0000_ffef));
		add_row("same_dest", ANY_GAP,
			assemble("addiu", 17, 0, 'h0001), assemble("addiu", 17, 0, 'h0002),
			wr(17, 32'h0000_0001), wr(17, 32'h0000_0002));
		add_row("fwd_gap0", 0,
			assemble("addu", 18, 17, 17), assemble("addiu", 19, 17, 'h0010),
			wr(18, 32'h0000_0004), wr(19, 32'h0000_0012));
		add_row("bypass_gap1", 1,
			assemble("addiu", 20, 18, 'h0001), assemble("subu", 21, 19, 18),
			wr(20, 32'h0000_0005), wr(21, 32'h0000_000e));
		add_row("stored_gap2", 2,
			assemble("addu", 22, 20, 21), assemble("or", 23, 17, 20),
			wr(22, 32'h0000_0013), wr(23, 32'h0000_0007));
		add_row("no_write", ANY_GAP,
			assemble("addiu", 0, 1, 'h1234), assemble("lw", 3, 1, 0),
			NO_WRITE, NO_WRITE);
		add_row("read_zero", 0,
			assemble("addiu", 24, 0, 'h0007), assemble("or", 25, 0, 3),
			wr(24, 32'h0000_0007), wr(25, 32'h0000_8f00));
	endtask

	task automatic compare_value(string name, value_t expected, value_t actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected 0x%h actual 0x%h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_lane(string lane, pipe_pkg::RegWriteReq_t expected,
		pipe_pkg::RegWriteReq_t actual);
		compare_value({lane, ".we"}, value_t'(expected.we), value_t'(actual.we));
		// Address and data are don't-care on an idle lane
		if (expected.we)
		begin
			compare_value({lane, ".waddr"}, value_t'(expected.waddr), value_t'(actual.waddr));
			compare_value({lane, ".wdata"}, expected.wdata, actual.wdata);
		end
	endtask

	task automatic check_writeback();
		int errors_before;
		int latency;
		errors_before = errors;
		if (rows_done >= strobe_cycles.size())
		begin
			$display("wb_valid pulsed at cycle %0d with no strobe outstanding", cycle);
			errors++;
			return;
		end
		latency = cycle - strobe_cycles[rows_done] - 1;
		if (latency != 2)
		begin
			$display("Row %0d writeback came %0d cycles after its strobe, not 2", rows_done, latency);
			errors++;
		end
		check_lane("wb_a", exp_a[rows_done], wb_a);
		check_lane("wb_b", exp_b[rows_done], wb_b);
		if (errors == errors_before)
		begin
			rows_passed++;
			$display("row %0d %s: ok", rows_done, names[rows_done]);
		end
		else
		begin
			rows_failed++;
			$display("row %0d %s: FAILED", rows_done, names[rows_done]);
		end
		rows_done++;
	endtask

	task automatic drive_rows();
		int gap;
		for (int i = 0; i < pairs.size(); i++)
		begin
			gap = (gaps[i] < 0) ? int'($urandom % 3) : gaps[i];
			repeat (gap)
			begin
				@(posedge clk);
				pair_valid <= 1'b0;
			end
			@(posedge clk);
			pair_valid <= 1'b1;
			inst_pair  <= pairs[i];
			strobe_cycles.push_back(cycle);
		end
		@(posedge clk);
		pair_valid <= 1'b0;
	endtask

	always @(posedge clk)
	begin
		if (wb_valid === 1'b1)
			check_writeback();
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= limit)
		begin
			$display("Timeout at cycle %0d, %0d writebacks seen for %0d strobes sent",
				cycle, rows_done, strobe_cycles.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(SEED));
		rst_n      = 1'b0;
		pair_valid = 1'b0;
		inst_pair  = '0;
		build_table();
		limit = 16 + pairs.size() * 5 + 20;
		repeat (16)
		begin
			@(posedge clk);
			// First edge only applies the reset
			if (cycle > 0)
				compare_value("wb_valid in reset", '0, value_t'(wb_valid));
		end
		rst_n <= 1'b1;
		drive_rows();
		wait (rows_done == pairs.size());
		// Catch any extra pulse
		repeat (4) @(posedge clk);
		$display("rows passed %0d, rows failed %0d, errors %0d", rows_passed, rows_failed, errors);
		if (errors == 0 && rows_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_decode.sv
hdl/gpr_file.sv
hdl/alu.sv
hdl/pair_execute.sv
hdl/dual_issue_core.sv
dv/core_tb.sv

// ==== Makefile ====
TOP             ?= core_tb
SEED            ?= 40441
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ps -j 0
BUILD_DIR       ?= obj_dir
FILELIST        ?= project.f
PASS_TEXT       := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: TOP SEED VERILATOR VERILATOR_FLAGS BUILD_DIR FILELIST"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
